/* Bender.yml */
package:
  name: iq

sources:
  - src/iq_pkg.sv
  - src/iq_init_fsm.sv
  - src/iq_occupancy.sv
  - src/iq_ptr.sv
  - src/iq_storage.sv
  - src/iq_top.sv
  - target: test
    files:
      - dv/iq_tb.sv

/* dv/iq_tb.sv */
// Testbench for the two-thread instruction queue.
// A model queue per thread is updated at each rising edge; concurrent assertions
// compare write_stall, read_avail and the shown read lanes against it.
`timescale 1ns/100ps
`default_nettype none

module iq_tb;

  logic                                              clk;
  logic                                              rst;
  logic                                              write_wen;
  logic                                              write_thread;
  logic [iq_pkg::wr_lanes-1:0]                       write_lane_en;
  logic [iq_pkg::wr_lanes-1:0][iq_pkg::instr_w-1:0]  write_instr;
  logic [iq_pkg::wr_lanes-1:0][iq_pkg::other_w-1:0]  write_other;
  logic                                              write_stall;
  logic                                              read_clk_en;
  logic                                              read_thread;
  logic [iq_pkg::rd_lanes-1:0]                       read_lane_en;
  logic [iq_pkg::rd_lanes-1:0]                       read_avail;
  logic [iq_pkg::rd_lanes-1:0][iq_pkg::instr_w-1:0]  read_instr;
  logic [iq_pkg::rd_lanes-1:0][iq_pkg::other_w-1:0]  read_other;
  logic                                              except;
  logic                                              except_thread;

  int          errors = 0;
  int          init_left = 32;
  logic [15:0] lfsr_q = 16'd79;
  logic [39:0] mq [2][$];
  int          exp_cnt [2];
  logic [39:0] exp_word [2][3];
  logic        exp_stall;
  logic [2:0]  exp_avail;

  iq_top iq_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // enabled lanes counted from lane 0 up to the first gap.
  function automatic int low_lane_run(input logic [3:0] en);
    int n;
    n = 0;
    for (int k = 0; k < 4; k++) begin
      if (en[k] && n == k) n++;
    end
    return n;
  endfunction

  function automatic logic [3:0] lanes_mask(input int n);
    logic [3:0] m;
    m = '0;
    for (int k = 0; k < n; k++) m[k] = 1'b1;
    return m;
  endfunction

  function automatic int clamp_read(input logic thr, input int want);
    int m;
    m = (exp_cnt[thr] > 3) ? 3 : exp_cnt[thr];
    return (want < m) ? want : m;
  endfunction

  task automatic model_step();
    int          wn;
    int          rn;
    logic        busy;
    logic        wr_ok;
    busy = (init_left != 0);
    wn = low_lane_run(write_lane_en);
    rn = low_lane_run({1'b0, read_lane_en});
    // stall is decided on the occupancy before this edge.
    wr_ok = write_wen && !busy && (mq[write_thread].size() <= iq_pkg::stall_level);
    if (init_left != 0) init_left--;
    if (except) begin
      mq[except_thread].delete();
    end else begin
      if (read_clk_en && !busy) begin
        for (int k = 0; k < rn; k++) begin
          if (mq[read_thread].size() > 0) void'(mq[read_thread].pop_front());
        end
      end
      if (wr_ok) begin
        for (int k = 0; k < wn; k++) mq[write_thread].push_back({write_instr[k], write_other[k]});
      end
    end
  endtask

  task automatic refresh_expect();
    for (int t = 0; t < 2; t++) begin
      exp_cnt[t] = mq[t].size();
      for (int i = 0; i < 3; i++) exp_word[t][i] = (i < mq[t].size()) ? mq[t][i] : '0;
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      mq[0].delete();
      mq[1].delete();
      init_left = 32;
    end else begin
      model_step();
    end
    refresh_expect();
  end

  assign exp_stall = (init_left != 0) || (exp_cnt[write_thread] > iq_pkg::stall_level);

  always_comb begin
    for (int i = 0; i < 3; i++) exp_avail[i] = (init_left == 0) && (exp_cnt[read_thread] > i);
  end

  stall_matches: assert property (@(posedge clk) disable iff (rst) write_stall == exp_stall)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: write_stall got %b expected %b",
               $time, $sampled(write_stall), $sampled(exp_stall));
    end

  avail_matches: assert property (@(posedge clk) disable iff (rst) read_avail == exp_avail)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: read_avail got %b expected %b",
               $time, $sampled(read_avail), $sampled(exp_avail));
    end

  for (genvar i = 0; i < 3; i++) begin : lane_chk
    logic        shown;
    logic [39:0] exp_val;

    // during init every lane must read zero.
    assign shown = (init_left != 0) || (exp_cnt[read_thread] > i);
    assign exp_val = (init_left != 0) ? '0 : exp_word[read_thread][i];

    instr_matches: assert property (
      @(posedge clk) disable iff (rst) shown |-> read_instr[i] == exp_val[39:8]
    ) else begin
      errors++;
      $display("CHECK FAILED at %0t: read_instr[%0d] got %h expected %h",
               $time, i, $sampled(read_instr[i]), $sampled(exp_val[39:8]));
    end

    other_matches: assert property (
      @(posedge clk) disable iff (rst) shown |-> read_other[i] == exp_val[7:0]
    ) else begin
      errors++;
      $display("CHECK FAILED at %0t: read_other[%0d] got %h expected %h",
               $time, i, $sampled(read_other[i]), $sampled(exp_val[7:0]));
    end
  end

  // drives one cycle of inputs at a falling edge, then waits for the next one.
  task automatic drive(input logic wen, input logic wthr, input int wn, input logic ren,
                       input logic rthr, input int rn, input logic exc, input logic ethr);
    write_wen = wen;
    write_thread = wthr;
    write_lane_en = lanes_mask(wn);
    for (int k = 0; k < 4; k++) begin
      write_instr[k] = rand_bits(32);
      write_other[k] = rand_bits(8);
    end
    read_clk_en = ren;
    read_thread = rthr;
    read_lane_en = 3'(lanes_mask(rn));
    except = exc;
    except_thread = ethr;
    @(negedge clk);
  endtask

  task automatic random_traffic(input int cycles, input logic both);
    logic wen;
    logic wthr;
    logic rthr;
    int   wn;
    int   rn;
    for (int c = 0; c < cycles; c++) begin
      wen = (rand_bits(2) != 0);
      wthr = both ? rand_bits(1) : 1'b0;
      wn = rand_bits(2) + 1;
      rthr = both ? rand_bits(1) : 1'b0;
      rn = clamp_read(rthr, rand_bits(2));
      drive(wen, wthr, wn, 1'b1, rthr, rn, 1'b0, 1'b0);
    end
  endtask

  task automatic drain(input logic thr);
    int n;
    n = 0;
    while (exp_cnt[thr] > 0 && n < 40) begin
      drive(1'b0, 1'b0, 0, 1'b1, thr, clamp_read(thr, 3), 1'b0, 1'b0);
      n++;
    end
    if (exp_cnt[thr] > 0) begin
      errors++;
      $display("timeout: thread %0d did not drain within 40 cycles", thr);
    end
  endtask

  task automatic end_test(input string name, input int mark);
    if (errors == mark) $display("test %s: pass", name);
    else $display("test %s: fail with %0d errors", name, errors - mark);
  endtask

  initial begin
    int n;
    int mark;
    rst = 1'b1;
    write_wen = 1'b0;
    write_thread = 1'b0;
    write_lane_en = '0;
    write_instr = '0;
    write_other = '0;
    read_clk_en = 1'b0;
    read_thread = 1'b0;
    read_lane_en = '0;
    except = 1'b0;
    except_thread = 1'b0;
    repeat (3) @(negedge clk);
    rst = 1'b0;

    // writes offered during the clearing pass must be blocked.
    mark = errors;
    n = 0;
    while (write_stall && n < 100) begin
      drive(1'b1, 1'b0, 4, 1'b0, 1'b0, 0, 1'b0, 1'b0);
      n++;
    end
    if (n >= 100) $display("timeout: write_stall stayed high after reset");
    init_len: assert (n == 32) else begin
      errors++;
      $display("CHECK FAILED at %0t: write_stall high cycles got %0d expected 32", $time, n);
    end
    end_test("clearing pass", mark);

    mark = errors;
    random_traffic(240, 1'b0);
    drain(1'b0);
    end_test("fifo order", mark);

    mark = errors;
    random_traffic(300, 1'b1);
    drain(1'b0);
    drain(1'b1);
    end_test("thread independence", mark);

    mark = errors;
    n = 0;
    while (!write_stall && n < 10) begin
      drive(1'b1, 1'b1, 4, 1'b0, 1'b1, 0, 1'b0, 1'b0);
      n++;
    end
    if (!write_stall) begin
      errors++;
      $display("timeout: write_stall never rose while filling thread 1");
    end
    repeat (3) drive(1'b1, 1'b1, 4, 1'b0, 1'b1, 0, 1'b0, 1'b0);
    drive(1'b0, 1'b0, 0, 1'b0, 1'b1, 0, 1'b0, 1'b0);
    drain(1'b1);
    end_test("stall", mark);

    mark = errors;
    drive(1'b1, 1'b0, 4, 1'b0, 1'b0, 0, 1'b0, 1'b0);
    drive(1'b1, 1'b0, 2, 1'b0, 1'b0, 0, 1'b0, 1'b0);
    drive(1'b1, 1'b1, 4, 1'b0, 1'b0, 0, 1'b0, 1'b0);
    drive(1'b1, 1'b1, 1, 1'b0, 1'b0, 0, 1'b0, 1'b0);
    // the write and read in the exception cycle are both cancelled.
    drive(1'b1, 1'b0, 4, 1'b1, 1'b0, 2, 1'b1, 1'b0);
    drive(1'b0, 1'b0, 0, 1'b0, 1'b0, 0, 1'b0, 1'b0);
    drive(1'b1, 1'b0, 3, 1'b0, 1'b0, 0, 1'b0, 1'b0);
    drain(1'b0);
    drain(1'b1);
    end_test("exception flush", mark);

    $display("tests run: 5, failed checks: %0d", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
src/iq_pkg.sv
src/iq_init_fsm.sv
src/iq_occupancy.sv
src/iq_ptr.sv
src/iq_storage.sv
src/iq_top.sv
dv/iq_tb.sv

/* src/iq_init_fsm.sv */
// Post-reset clearing sequencer for the queue storage.
// Walks every thread and slot once, thread in the top index bit, then stays in run.
// init is also high while rst is held.
`timescale 1ns/100ps
`default_nettype none

module iq_init_fsm (
  input  wire logic               clk,
  input  wire logic               rst,
  output logic                    init,
  output logic                    clr_thread,
  output iq_pkg::slot_addr_u      clr_slot
);

  logic [1:0] state;
  logic [4:0] idx;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= iq_pkg::st_clearing;
      idx <= 5'd0;
    end else begin
      case (state)
        iq_pkg::st_clearing: begin
          idx <= idx + 5'd1;
          if (idx == 5'(iq_pkg::init_cycles - 1)) begin
            state <= iq_pkg::st_run;
          end
        end
        iq_pkg::st_run: begin
          state <= iq_pkg::st_run;
        end
        // idle and any stray encoding restart the clearing pass.
        default: begin
          state <= iq_pkg::st_clearing;
          idx <= 5'd0;
        end
      endcase
    end
  end

  assign init = (state != iq_pkg::st_run);
  assign clr_thread = idx[4];
  assign clr_slot.idx = idx[3:0];

endmodule

`default_nettype wire

/* src/iq_occupancy.sv */
// Entry counter for one thread of the queue.
// push and pop counts must already be gated by the caller's fire conditions.
// flush wins over any push or pop in the same cycle.
`timescale 1ns/100ps
`default_nettype none

module iq_occupancy (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic                        flush,
  input  wire logic [2:0]                  push_cnt,
  input  wire logic [1:0]                  pop_cnt,
  output logic [iq_pkg::cnt_w-1:0]         count,
  output logic                             stall,
  output logic [iq_pkg::rd_lanes-1:0]      avail
);

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (flush) begin
      count <= '0;
    end else begin
      // a simultaneous push and pop nets out here.
      count <= count + {2'b00, push_cnt} - {3'b000, pop_cnt};
    end
  end

  // stall once a full write group could no longer fit.
  assign stall = (count > iq_pkg::stall_level);

  always_comb begin
    for (int i = 0; i < iq_pkg::rd_lanes; i++) begin
      avail[i] = (count > i[iq_pkg::cnt_w-1:0]);
    end
  end

  count_in_range: assert property (
    @(posedge clk) disable iff (rst)
    count <= iq_pkg::depth
  );

  // the reader must stay within the lanes flagged as available.
  pop_within_count: assert property (
    @(posedge clk) disable iff (rst)
    {3'b000, pop_cnt} <= count
  );

endmodule

`default_nettype wire

/* src/iq_pkg.sv */
// Sizes, slot address type and lane helper for the two-thread instruction queue.
// The slot address is 4 bits: 2 bank bits over 2 row bits, 16 entries per thread.
// Lane enables are assumed contiguous from lane 0; anything above a gap is ignored.
`default_nettype none

package iq_pkg;

  localparam int instr_w     = 32;
  localparam int other_w     = 8;
  localparam int depth       = 16;
  localparam int slot_w      = 4;
  localparam int bank_count  = 4;
  localparam int wr_lanes    = 4;
  localparam int rd_lanes    = 3;
  localparam int threads     = 2;
  localparam int stall_level = depth - wr_lanes;
  localparam int cnt_w       = 5;
  localparam int init_cycles = threads * depth;

  // init fsm encodings.
  localparam logic [1:0] st_idle     = 2'd0;
  localparam logic [1:0] st_clearing = 2'd1;
  localparam logic [1:0] st_run      = 2'd2;

  // flat index for pointer math, bank/row for the storage select.
  typedef union packed {
    logic [slot_w-1:0] idx;
    struct packed {
      logic [$clog2(bank_count)-1:0]        bank;
      logic [slot_w-$clog2(bank_count)-1:0] row;
    } f;
  } slot_addr_u;

  // number of set lanes counted up from lane 0, stopping at the first clear bit.
  function automatic logic [2:0] lane_count(input logic [wr_lanes-1:0] en);
    logic [2:0] n;
    logic       run;
    n = 3'd0;
    run = 1'b1;
    for (int i = 0; i < wr_lanes; i++) begin
      run = run & en[i];
      n = n + {2'b00, run};
    end
    return n;
  endfunction

endpackage

`default_nettype wire

/* src/iq_ptr.sv */
// Head and tail pointers for both threads.
// Pointers wrap modulo the 16-entry depth through the flat slot index.
// A flush clears both pointers of the flushed thread and ignores its counts.
`timescale 1ns/100ps
`default_nettype none

module iq_ptr (
  input  wire logic         clk,
  input  wire logic         rst,
  input  wire logic         flush,
  input  wire logic         flush_thread,
  input  wire logic         push_thread,
  input  wire logic [2:0]   push_cnt,
  input  wire logic         pop_thread,
  input  wire logic [1:0]   pop_cnt,
  input  wire logic         rd_thread,
  input  wire logic         wr_thread,
  output iq_pkg::slot_addr_u head,
  output iq_pkg::slot_addr_u tail
);

  iq_pkg::slot_addr_u head_q [iq_pkg::threads];
  iq_pkg::slot_addr_u tail_q [iq_pkg::threads];

  always_ff @(posedge clk) begin
    for (int t = 0; t < iq_pkg::threads; t++) begin
      if (rst) begin
        head_q[t].idx <= '0;
        tail_q[t].idx <= '0;
      end else if (flush && (flush_thread == t[0])) begin
        head_q[t].idx <= '0;
        tail_q[t].idx <= '0;
      end else begin
        // the 4-bit sum drops the carry, which is the wrap.
        if (push_thread == t[0]) begin
          tail_q[t].idx <= tail_q[t].idx + {1'b0, push_cnt};
        end
        if (pop_thread == t[0]) begin
          head_q[t].idx <= head_q[t].idx + {2'b00, pop_cnt};
        end
      end
    end
  end

  assign head = head_q[rd_thread];
  assign tail = tail_q[wr_thread];

endmodule

`default_nettype wire

/* src/iq_storage.sv */
// Banked entry storage, 4 banks of 4 rows for each thread.
// Write lane i lands at tail + i and read lane i shows head + i, both modulo 16.
// clr has priority over writes and zeroes one slot per cycle.
`timescale 1ns/100ps
`default_nettype none

module iq_storage (
  input  wire logic                                              clk,
  input  wire logic                                              clr,
  input  wire logic                                              clr_thread,
  input  wire iq_pkg::slot_addr_u                                clr_slot,
  input  wire logic                                              wr_fire,
  input  wire logic                                              wr_thread,
  input  wire logic [iq_pkg::wr_lanes-1:0]                       wr_lane_en,
  input  wire iq_pkg::slot_addr_u                                tail,
  input  wire logic [iq_pkg::wr_lanes-1:0][iq_pkg::instr_w-1:0]  wr_instr,
  input  wire logic [iq_pkg::wr_lanes-1:0][iq_pkg::other_w-1:0]  wr_other,
  input  wire logic                                              rd_thread,
  input  wire iq_pkg::slot_addr_u                                head,
  output logic [iq_pkg::rd_lanes-1:0][iq_pkg::instr_w-1:0]       rd_instr,
  output logic [iq_pkg::rd_lanes-1:0][iq_pkg::other_w-1:0]       rd_other
);

  iq_pkg::slot_addr_u lane_addr [iq_pkg::wr_lanes];
  iq_pkg::slot_addr_u rd_addr [iq_pkg::rd_lanes];

  logic [iq_pkg::instr_w-1:0]
    slot_instr [iq_pkg::threads][iq_pkg::bank_count][iq_pkg::depth/iq_pkg::bank_count];
  logic [iq_pkg::other_w-1:0]
    slot_other [iq_pkg::threads][iq_pkg::bank_count][iq_pkg::depth/iq_pkg::bank_count];

  always_comb begin
    for (int i = 0; i < iq_pkg::wr_lanes; i++) begin
      lane_addr[i].idx = tail.idx + i[iq_pkg::slot_w-1:0];
    end
  end

  for (genvar b = 0; b < iq_pkg::bank_count; b++) begin : bank_gen
    for (genvar r = 0; r < iq_pkg::depth / iq_pkg::bank_count; r++) begin : row_gen
      logic [iq_pkg::wr_lanes-1:0] hit;
      logic                        clr_sel;
      logic [iq_pkg::instr_w-1:0]  w_instr;
      logic [iq_pkg::other_w-1:0]  w_other;

      // pick the write lane whose address lands on this bank and row.
      always_comb begin
        w_instr = '0;
        w_other = '0;
        for (int i = 0; i < iq_pkg::wr_lanes; i++) begin
          hit[i] = wr_fire && wr_lane_en[i] &&
                   (lane_addr[i].f.bank == b) && (lane_addr[i].f.row == r);
          if (hit[i]) begin
            w_instr = wr_instr[i];
            w_other = wr_other[i];
          end
        end
      end

      assign clr_sel = (clr_slot.f.bank == b) && (clr_slot.f.row == r);

      for (genvar t = 0; t < iq_pkg::threads; t++) begin : thr_gen
        logic [iq_pkg::instr_w-1:0] instr_q;
        logic [iq_pkg::other_w-1:0] other_q;

        always_ff @(posedge clk) begin
          if (clr) begin
            if (clr_sel && (clr_thread == t)) begin
              instr_q <= '0;
              other_q <= '0;
            end
          end else if ((|hit) && (wr_thread == t)) begin
            instr_q <= w_instr;
            other_q <= w_other;
          end
        end

        assign slot_instr[t][b][r] = instr_q;
        assign slot_other[t][b][r] = other_q;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < iq_pkg::rd_lanes; i++) begin
      rd_addr[i].idx = head.idx + i[iq_pkg::slot_w-1:0];
      rd_instr[i] = slot_instr[rd_thread][rd_addr[i].f.bank][rd_addr[i].f.row];
      rd_other[i] = slot_other[rd_thread][rd_addr[i].f.bank][rd_addr[i].f.row];
    end
  end

endmodule

`default_nettype wire

/* src/iq_top.sv */
// Two-thread instruction queue between fetch and decode.
// Writes take up to 4 lanes per cycle, reads show up to 3 lanes of read_thread.
// Writes offered while write_stall is high are dropped; fetch must hold them.
// An exception cancels all writes and reads of its cycle.
`timescale 1ns/100ps
`default_nettype none

module iq_top (
  input  wire logic                                              clk,
  input  wire logic                                              rst,
  input  wire logic                                              write_wen,
  input  wire logic                                              write_thread,
  input  wire logic [iq_pkg::wr_lanes-1:0]                       write_lane_en,
  input  wire logic [iq_pkg::wr_lanes-1:0][iq_pkg::instr_w-1:0]  write_instr,
  input  wire logic [iq_pkg::wr_lanes-1:0][iq_pkg::other_w-1:0]  write_other,
  output logic                                                   write_stall,
  input  wire logic                                              read_clk_en,
  input  wire logic                                              read_thread,
  input  wire logic [iq_pkg::rd_lanes-1:0]                       read_lane_en,
  output logic [iq_pkg::rd_lanes-1:0]                            read_avail,
  output logic [iq_pkg::rd_lanes-1:0][iq_pkg::instr_w-1:0]       read_instr,
  output logic [iq_pkg::rd_lanes-1:0][iq_pkg::other_w-1:0]       read_other,
  input  wire logic                                              except,
  input  wire logic                                              except_thread
);

  logic                init;
  logic                clr_thread;
  iq_pkg::slot_addr_u  clr_slot;
  iq_pkg::slot_addr_u  head;
  iq_pkg::slot_addr_u  tail;

  logic                write_fire;
  logic                read_fire;
  logic [2:0]          wr_cnt;
  logic [1:0]          rd_cnt;
  logic [2:0]          push_cnt;
  logic [1:0]          pop_cnt;
  logic [2:0]          push_t0;
  logic [2:0]          push_t1;
  logic [1:0]          pop_t0;
  logic [1:0]          pop_t1;

  logic [iq_pkg::cnt_w-1:0]    count_t0;
  logic [iq_pkg::cnt_w-1:0]    count_t1;
  logic [iq_pkg::cnt_w-1:0]    count_rd;
  logic                        stall_t0;
  logic                        stall_t1;
  logic [iq_pkg::rd_lanes-1:0] avail_t0;
  logic [iq_pkg::rd_lanes-1:0] avail_t1;

  logic [iq_pkg::rd_lanes-1:0][iq_pkg::instr_w-1:0] rd_instr_raw;
  logic [iq_pkg::rd_lanes-1:0][iq_pkg::other_w-1:0] rd_other_raw;

  assign wr_cnt = iq_pkg::lane_count(write_lane_en);
  assign rd_cnt = 2'(iq_pkg::lane_count({1'b0, read_lane_en}));

  assign write_stall = init | (write_thread ? stall_t1 : stall_t0);
  assign write_fire = write_wen & ~write_stall & ~except;
  assign read_fire = read_clk_en & ~init & ~except;

  assign push_cnt = write_fire ? wr_cnt : 3'd0;
  assign pop_cnt = read_fire ? rd_cnt : 2'd0;

  // steer the counts to the thread that owns them.
  assign push_t0 = write_thread ? 3'd0 : push_cnt;
  assign push_t1 = write_thread ? push_cnt : 3'd0;
  assign pop_t0 = read_thread ? 2'd0 : pop_cnt;
  assign pop_t1 = read_thread ? pop_cnt : 2'd0;

  assign read_avail = read_thread ? avail_t1 : avail_t0;
  assign count_rd = read_thread ? count_t1 : count_t0;

  // storage still holds stale contents until the clearing pass ends.
  assign read_instr = init ? '0 : rd_instr_raw;
  assign read_other = init ? '0 : rd_other_raw;

  iq_init_fsm init_fsm_inst (
    .clk        (clk),
    .rst        (rst),
    .init       (init),
    .clr_thread (clr_thread),
    .clr_slot   (clr_slot)
  );

  iq_occupancy occ_t0 (
    .clk      (clk),
    .rst      (rst),
    .flush    (except & ~except_thread),
    .push_cnt (push_t0),
    .pop_cnt  (pop_t0),
    .count    (count_t0),
    .stall    (stall_t0),
    .avail    (avail_t0)
  );

  iq_occupancy occ_t1 (
    .clk      (clk),
    .rst      (rst),
    .flush    (except & except_thread),
    .push_cnt (push_t1),
    .pop_cnt  (pop_t1),
    .count    (count_t1),
    .stall    (stall_t1),
    .avail    (avail_t1)
  );

  iq_ptr ptr_inst (
    .clk          (clk),
    .rst          (rst),
    .flush        (except),
    .flush_thread (except_thread),
    .push_thread  (write_thread),
    .push_cnt     (push_cnt),
    .pop_thread   (read_thread),
    .pop_cnt      (pop_cnt),
    .rd_thread    (read_thread),
    .wr_thread    (write_thread),
    .head         (head),
    .tail         (tail)
  );

  iq_storage storage_inst (
    .clk        (clk),
    .clr        (init),
    .clr_thread (clr_thread),
    .clr_slot   (clr_slot),
    .wr_fire    (write_fire),
    .wr_thread  (write_thread),
    .wr_lane_en (write_lane_en),
    .tail       (tail),
    .wr_instr   (write_instr),
    .wr_other   (write_other),
    .rd_thread  (read_thread),
    .head       (head),
    .rd_instr   (rd_instr_raw),
    .rd_other   (rd_other_raw)
  );

  // counter and pointers of one thread must agree modulo the depth.
  occ_matches_ptr: assert property (
    @(posedge clk) disable iff (rst)
    (read_thread == write_thread) |-> (count_rd[3:0] == 4'(tail.idx - head.idx))
  );

endmodule

`default_nettype wire
